//--- dv/periph_subsys_properties.sv
// AXI4-Lite handshake assertions for the peripheral subsystem.
// Bound into periph_subsys_top; fail_count is read by the testbench at the end.

`timescale 1ns/10ps
`default_nettype none

module periph_subsys_properties (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic awready_o,
  input wire logic wready_o,
  input wire logic bvalid_o,
  input wire logic bready_i,
  input wire logic arready_o,
  input wire logic rvalid_o,
  input wire logic rready_i
);

  int unsigned fail_count = 0;

  // No responses while in reset
  assert property (@(posedge clk_i) !rst_ni |-> !bvalid_o && !rvalid_o)
    else begin
      fail_count++;
      $error("Response valid during reset");
    end

  // Valid holds until the manager takes the beat
  assert property (@(posedge clk_i) disable iff (!rst_ni) bvalid_o && !bready_i |=> bvalid_o)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end
  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o && !rready_i |=> rvalid_o)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // AW and W are always taken together
  assert property (@(posedge clk_i) disable iff (!rst_ni) awready_o == wready_o)
    else begin
      fail_count++;
      $error("awready and wready differ");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) rvalid_o |-> !arready_o)
    else begin
      fail_count++;
      $error("Read accepted with an R beat pending");
    end

endmodule

bind periph_subsys_top periph_subsys_properties i_props (.*);

`default_nettype wire

//--- dv/periph_subsys_tb.sv
// Testbench for the peripheral subsystem.
// Runs reset, register, decode, timer and back-pressure tests over the
// AXI4-Lite port and checks every B and R beat against a register model.

`timescale 1ns/10ps
`default_nettype none

module periph_subsys_tb
  import periph_bus_pkg::*, periph_map_pkg::*;
;

  localparam logic [DataWidth-1:0] BootAddr  = 32'h1C00_0080;
  localparam int unsigned          TimerN    = 40;
  localparam int unsigned          WaitLimit = 200;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic [AddrWidth-1:0] awaddr;
  logic                 awvalid;
  logic                 awready;
  logic [DataWidth-1:0] wdata;
  logic [StrbWidth-1:0] wstrb;
  logic                 wvalid;
  logic                 wready;
  logic [1:0]           bresp;
  logic                 bvalid;
  logic                 bready;
  logic [AddrWidth-1:0] araddr;
  logic                 arvalid;
  logic                 arready;
  logic [DataWidth-1:0] rdata;
  logic [1:0]           rresp;
  logic                 rvalid;
  logic                 rready;
  logic [DataWidth-1:0] boot_addr;
  logic                 fetch_en;
  logic                 timer_irq;

  // Register model updated when a write is accepted
  logic [DataWidth-1:0] model_boot;
  logic                 model_fetch;
  logic                 model_ten;
  logic [DataWidth-1:0] model_cmp;

  // Expected beats in issue order
  logic [DataWidth-1:0] exp_rdata_q[$];
  logic [1:0]           exp_rresp_q[$];
  bit                   exp_rchk_q[$];
  logic [1:0]           exp_bresp_q[$];

  int seed = 88983;
  int errors = 0;
  int tests = 0;

  always #5 clk = ~clk;

  periph_subsys_top #(
    .BootAddrDefault ( BootAddr )
  ) uut (
    .clk_i          ( clk       ),
    .rst_ni         ( rst_n     ),
    .awaddr_i       ( awaddr    ),
    .awvalid_i      ( awvalid   ),
    .awready_o      ( awready   ),
    .wdata_i        ( wdata     ),
    .wstrb_i        ( wstrb     ),
    .wvalid_i       ( wvalid    ),
    .wready_o       ( wready    ),
    .bresp_o        ( bresp     ),
    .bvalid_o       ( bvalid    ),
    .bready_i       ( bready    ),
    .araddr_i       ( araddr    ),
    .arvalid_i      ( arvalid   ),
    .arready_o      ( arready   ),
    .rdata_o        ( rdata     ),
    .rresp_o        ( rresp     ),
    .rvalid_o       ( rvalid    ),
    .rready_i       ( rready    ),
    .boot_addr_o    ( boot_addr ),
    .fetch_enable_o ( fetch_en  ),
    .timer_irq_o    ( timer_irq )
  );

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_w,
                                                       input logic [DataWidth-1:0] new_w,
                                                       input logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] mask;
    for (int i = 0; i < StrbWidth; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // Expected {resp, data} of a read; count and status are not predicted here
  function automatic logic [DataWidth+1:0] expect_read(input logic [AddrWidth-1:0] addr);
    int unsigned a;
    int unsigned off;
    a   = addr;
    off = a % RegionSize;
    if (a >= SocCtrlBase && a < SocCtrlBase + RegionSize) begin
      if (off == SocBootAddrOffset) return {RespOkay, model_boot};
      if (off == SocFetchEnOffset) return {RespOkay, 31'b0, model_fetch};
      return {RespOkay, 32'b0};
    end
    if (a >= TimerBase && a < TimerBase + RegionSize) begin
      if (off == TimerCtrlOffset) return {RespOkay, 31'b0, model_ten};
      if (off == TimerCmpOffset) return {RespOkay, model_cmp};
      return {RespOkay, 32'b0};
    end
    return {RespDecErr, ErrorRdata};
  endfunction

  function automatic void update_model(input logic [AddrWidth-1:0] addr,
                                       input logic [DataWidth-1:0] data,
                                       input logic [StrbWidth-1:0] strb);
    if (addr == SocCtrlBase + SocBootAddrOffset) begin
      model_boot = merge_bytes(model_boot, data, strb);
    end else if (addr == SocCtrlBase + SocFetchEnOffset && strb[0]) begin
      model_fetch = data[0];
    end else if (addr == TimerBase + TimerCtrlOffset && strb[0]) begin
      model_ten = data[0];
    end else if (addr == TimerBase + TimerCmpOffset) begin
      model_cmp = merge_bytes(model_cmp, data, strb);
    end
  endfunction

  // ----------------------------------------------------------------------
  // Checks and run control
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [DataWidth-1:0] exp_v,
                             input logic [DataWidth-1:0] got);
    assert (got === exp_v) else begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp_v, got);
      errors++;
    end
  endtask

  task automatic end_run();
    int total;
    total = errors + uut.i_props.fail_count;
    $display("Tests run: %0d, errors: %0d", tests, total);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout at %0t: no %s within the wait limit", $time, what);
    errors++;
    end_run();
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests, name, errors - errs_before);
    end
  endtask

  // Compare every B and R beat
  always @(posedge clk) begin : compare_beats
    logic [DataWidth-1:0] exp_d;
    bit                   chk;
    if (rst_n && bvalid && bready) begin
      assert (exp_bresp_q.size() != 0) begin
        check_value("bresp_o", DataWidth'(exp_bresp_q.pop_front()), DataWidth'(bresp));
      end else begin
        $display("Write response arrived at %0t with no write outstanding", $time);
        errors++;
      end
    end
    if (rst_n && rvalid && rready) begin
      assert (exp_rresp_q.size() != 0) begin
        exp_d = exp_rdata_q.pop_front();
        chk   = exp_rchk_q.pop_front();
        check_value("rresp_o", DataWidth'(exp_rresp_q.pop_front()), DataWidth'(rresp));
        if (chk) begin
          check_value("rdata_o", exp_d, rdata);
        end
      end else begin
        $display("Read response arrived at %0t with no read outstanding", $time);
        errors++;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Bus tasks
  // ----------------------------------------------------------------------
  task automatic start_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                             input logic [StrbWidth-1:0] strb);
    logic [DataWidth+1:0] ref_v;
    ref_v = expect_read(addr);
    exp_bresp_q.push_back(ref_v[DataWidth+1:DataWidth]);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
  endtask

  task automatic finish_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                              input logic [StrbWidth-1:0] strb);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < WaitLimit);
    if (!(awready && wready)) begin
      fail_timeout("write acceptance");
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    update_model(addr, data, strb);
  endtask

  task automatic wait_write_resp();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(bvalid && bready) && n < WaitLimit);
    if (!(bvalid && bready)) begin
      fail_timeout("write response");
    end
  endtask

  task automatic start_read(input logic [AddrWidth-1:0] addr, input bit chk);
    logic [DataWidth+1:0] ref_v;
    ref_v = expect_read(addr);
    exp_rdata_q.push_back(ref_v[DataWidth-1:0]);
    exp_rresp_q.push_back(ref_v[DataWidth+1:DataWidth]);
    exp_rchk_q.push_back(chk);
    araddr  <= addr;
    arvalid <= 1'b1;
  endtask

  task automatic finish_read();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < WaitLimit);
    if (!arready) begin
      fail_timeout("read acceptance");
    end
    arvalid <= 1'b0;
  endtask

  task automatic wait_read_resp(output logic [DataWidth-1:0] data);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(rvalid && rready) && n < WaitLimit);
    if (!(rvalid && rready)) begin
      fail_timeout("read response");
    end
    data = rdata;
  endtask

  task automatic write_reg(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                           input logic [StrbWidth-1:0] strb);
    @(posedge clk);
    start_write(addr, data, strb);
    finish_write(addr, data, strb);
    wait_write_resp();
  endtask

  task automatic read_reg(input logic [AddrWidth-1:0] addr, input bit chk,
                          output logic [DataWidth-1:0] data);
    @(posedge clk);
    start_read(addr, chk);
    finish_read();
    wait_read_resp(data);
  endtask

  task automatic wait_irq_rise();
    int n;
    n = 0;
    while (timer_irq !== 1'b1 && n < 4 * TimerN) begin
      @(posedge clk);
      n++;
    end
    if (timer_irq !== 1'b1) begin
      fail_timeout("timer interrupt");
    end
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  initial begin
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] data;
    logic [DataWidth-1:0] rd;
    logic [StrbWidth-1:0] strb;
    int                   mark;
    int                   hold;
    rst_n   <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b1;
    model_boot  = BootAddr;
    model_fetch = 1'b0;
    model_ten   = 1'b0;
    model_cmp   = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values on the outputs and through the bus
    mark = errors;
    @(posedge clk);
    check_value("boot_addr_o", BootAddr, boot_addr);
    check_value("fetch_enable_o", '0, DataWidth'(fetch_en));
    read_reg(SocCtrlBase + SocBootAddrOffset, 1'b1, rd);
    read_reg(SocCtrlBase + SocFetchEnOffset, 1'b1, rd);
    report_test("reset values", mark);

    mark = errors;
    for (int i = 0; i < 12; i++) begin
      addr = ($random(seed) & 1) ? SocFetchEnOffset : SocBootAddrOffset;
      data = $random(seed);
      strb = $random(seed);
      write_reg(addr, data, strb);
      read_reg(addr, 1'b1, rd);
      check_value("boot_addr_o", model_boot, boot_addr);
      check_value("fetch_enable_o", DataWidth'(model_fetch), DataWidth'(fetch_en));
    end
    report_test("soc control writes", mark);

    // Unmapped space and unimplemented offsets
    mark = errors;
    read_reg(12'h800, 1'b1, rd);
    write_reg(12'h300, $random(seed), 4'hF);
    read_reg(SocCtrlBase + SocBootAddrOffset, 1'b1, rd);
    read_reg(SocCtrlBase + SocFetchEnOffset, 1'b1, rd);
    read_reg(TimerBase + TimerCtrlOffset, 1'b1, rd);
    read_reg(TimerBase + TimerCmpOffset, 1'b1, rd);
    read_reg(SocCtrlBase + 'h10, 1'b1, rd);
    read_reg(TimerBase + 'h20, 1'b1, rd);
    report_test("address decode", mark);

    mark = errors;
    write_reg(TimerBase + TimerCmpOffset, TimerN, 4'hF);
    write_reg(TimerBase + TimerCtrlOffset, 32'h1, 4'h1);
    read_reg(TimerBase + TimerCmpOffset, 1'b1, rd);
    wait_irq_rise();
    read_reg(TimerBase + TimerCountOffset, 1'b0, rd);
    assert (rd <= TimerN) else begin
      $display("Error at %0t: rdata_o counter %0d, expected at most %0d", $time, rd, TimerN);
      errors++;
    end
    write_reg(TimerBase + TimerStatusOffset, 32'h1, 4'h1);
    check_value("timer_irq_o", '0, DataWidth'(timer_irq));
    wait_irq_rise();
    read_reg(TimerBase + TimerStatusOffset, 1'b0, rd);
    check_value("rdata_o", 32'h1, rd);
    write_reg(TimerBase + TimerCtrlOffset, 32'h0, 4'h1);
    report_test("timer interrupt", mark);

    // Stall B and R, then queue a second write and read behind them
    mark = errors;
    hold = 2 + ($unsigned($random(seed)) % 8);
    data = $random(seed);
    @(posedge clk);
    bready <= 1'b0;
    rready <= 1'b0;
    start_write(SocCtrlBase + SocBootAddrOffset, data, 4'hF);
    finish_write(SocCtrlBase + SocBootAddrOffset, data, 4'hF);
    start_read(SocCtrlBase + SocBootAddrOffset, 1'b1);
    finish_read();
    data = {31'b0, !model_fetch};
    start_write(SocCtrlBase + SocFetchEnOffset, data, 4'h1);
    start_read(SocCtrlBase + SocFetchEnOffset, 1'b1);
    repeat (hold) begin
      @(posedge clk);
      assert (bvalid && rvalid && !awready && !arready) else begin
        $display("A stalled channel moved under back-pressure at %0t", $time);
        errors++;
      end
    end
    bready <= 1'b1;
    rready <= 1'b1;
    fork
      wait_write_resp();
      wait_read_resp(rd);
    join
    fork
      finish_write(SocCtrlBase + SocFetchEnOffset, data, 4'h1);
      finish_read();
    join
    fork
      wait_write_resp();
      wait_read_resp(rd);
    join
    read_reg(SocCtrlBase + SocFetchEnOffset, 1'b1, rd);
    check_value("fetch_enable_o", DataWidth'(model_fetch), DataWidth'(fetch_en));
    report_test("back-pressure", mark);

    end_run();
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/periph_bus_pkg.sv
hw/periph_map_pkg.sv
hw/axil_periph_port.sv
hw/soc_ctrl_regs.sv
hw/periph_timer.sv
hw/periph_subsys_top.sv
dv/periph_subsys_properties.sv
dv/periph_subsys_tb.sv

//--- hw/axil_periph_port.sv
// AXI4-Lite subordinate port in front of the peripheral register blocks.
// Accepts one write and one read at a time, decodes the address into a region,
// strobes the selected block and answers unmapped addresses with DECERR.

`timescale 1ns/10ps
`default_nettype none

module axil_periph_port
  import periph_bus_pkg::*, periph_map_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // AXI4-Lite write side
  input  wire logic [AddrWidth-1:0]   awaddr_i,
  input  wire logic                   awvalid_i,
  output logic                        awready_o,
  input  wire logic [DataWidth-1:0]   wdata_i,
  input  wire logic [StrbWidth-1:0]   wstrb_i,
  input  wire logic                   wvalid_i,
  output logic                        wready_o,
  output logic [1:0]                  bresp_o,
  output logic                        bvalid_o,
  input  wire logic                   bready_i,
  // AXI4-Lite read side
  input  wire logic [AddrWidth-1:0]   araddr_i,
  input  wire logic                   arvalid_i,
  output logic                        arready_o,
  output logic [DataWidth-1:0]        rdata_o,
  output logic [1:0]                  rresp_o,
  output logic                        rvalid_o,
  input  wire logic                   rready_i,
  // Register block side
  output logic                        soc_we_o,
  output logic                        timer_we_o,
  output logic [OffsetWidth-1:0]      wr_offset_o,
  output logic [DataWidth-1:0]        wr_data_o,
  output logic [StrbWidth-1:0]        wr_strb_o,
  output logic [OffsetWidth-1:0]      rd_offset_o,
  input  wire logic [DataWidth-1:0]   soc_rdata_i,
  input  wire logic [DataWidth-1:0]   timer_rdata_i
);

  logic                 wr_accept;
  logic                 rd_accept;
  logic                 aw_soc;
  logic                 aw_timer;
  logic                 ar_soc;
  logic                 ar_timer;
  logic [DataWidth-1:0] rd_data;

  // Region hit test on a full bus address
  function automatic logic in_region(input logic [AddrWidth-1:0] addr, input int unsigned base);
    int unsigned a;
    a = addr;
    return (a >= base) && (a < base + RegionSize);
  endfunction

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  assign aw_soc   = in_region(awaddr_i, SocCtrlBase);
  assign aw_timer = in_region(awaddr_i, TimerBase);
  assign ar_soc   = in_region(araddr_i, SocCtrlBase);
  assign ar_timer = in_region(araddr_i, TimerBase);

  // ----------------------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------------------
  // AW and W are taken together, only with no B beat outstanding
  assign wr_accept = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;

  assign soc_we_o    = wr_accept && aw_soc;
  assign timer_we_o  = wr_accept && aw_timer;
  assign wr_offset_o = awaddr_i[OffsetWidth-1:0];
  assign wr_data_o   = wdata_i;
  assign wr_strb_o   = wstrb_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_o <= 1'b0;
      bresp_o  <= RespOkay;
    end else if (wr_accept) begin
      bvalid_o <= 1'b1;
      bresp_o  <= (aw_soc || aw_timer) ? RespOkay : RespDecErr;
    end else if (bready_i) begin
      bvalid_o <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------------------
  assign rd_accept   = arvalid_i && !rvalid_o;
  assign arready_o   = rd_accept;
  assign rd_offset_o = araddr_i[OffsetWidth-1:0];

  // Blocks answer combinationally for rd_offset_o
  always_comb begin
    if (ar_soc) begin
      rd_data = soc_rdata_i;
    end else if (ar_timer) begin
      rd_data = timer_rdata_i;
    end else begin
      rd_data = ErrorRdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
      rresp_o  <= RespOkay;
    end else if (rd_accept) begin
      rvalid_o <= 1'b1;
      rresp_o  <= (ar_soc || ar_timer) ? RespOkay : RespDecErr;
    end else if (rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  // Read data held until the R beat is taken
  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/periph_bus_pkg.sv
// Bus-level constants for the peripheral subsystem.
// Widths and response codes of the AXI4-Lite port, plus the byte-strobe merge
// used by every register block behind the port.

`default_nettype none

package periph_bus_pkg;

  localparam int unsigned AddrWidth   = 12;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned StrbWidth   = DataWidth / 8;
  localparam int unsigned OffsetWidth = 8;

  // AXI response codes in use
  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespDecErr = 2'b11;

  // Merge new bytes into an old word under the write strobes
  function automatic logic [DataWidth-1:0] apply_strb(input logic [DataWidth-1:0] old_q,
                                                      input logic [DataWidth-1:0] new_d,
                                                      input logic [StrbWidth-1:0] strb);
    logic [DataWidth-1:0] merged;
    merged = old_q;
    for (int b = 0; b < StrbWidth; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- hw/periph_map_pkg.sv
// Address map of the peripheral subsystem.
// Region bases and sizes are used by the bus port for decode; the register
// offsets belong to the blocks that implement them.

`default_nettype none

package periph_map_pkg;

  // ----------------------------------------------------------------------
  // Regions
  // ----------------------------------------------------------------------
  localparam int unsigned SocCtrlBase = 'h000;
  localparam int unsigned TimerBase   = 'h100;
  localparam int unsigned RegionSize  = 'h100;

  // ----------------------------------------------------------------------
  // Register offsets inside a region
  // ----------------------------------------------------------------------
  localparam int unsigned SocBootAddrOffset = 'h0;
  localparam int unsigned SocFetchEnOffset  = 'h4;

  localparam int unsigned TimerCtrlOffset   = 'h0;
  localparam int unsigned TimerCountOffset  = 'h4;
  localparam int unsigned TimerCmpOffset    = 'h8;
  localparam int unsigned TimerStatusOffset = 'hC;

  // Returned on reads that hit no region
  localparam logic [31:0] ErrorRdata = 32'hBADCAB1E;

endpackage

`default_nettype wire

//--- hw/periph_subsys_top.sv
// Peripheral subsystem top level.
// One AXI4-Lite port in front of the SoC control registers and the timer;
// BootAddrDefault sets the boot address seen after reset.

`timescale 1ns/10ps
`default_nettype none

module periph_subsys_top
  import periph_bus_pkg::*;
#(
  parameter logic [DataWidth-1:0] BootAddrDefault = 32'h0000_0080
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic [AddrWidth-1:0] awaddr_i,
  input  wire logic                 awvalid_i,
  output logic                      awready_o,
  input  wire logic [DataWidth-1:0] wdata_i,
  input  wire logic [StrbWidth-1:0] wstrb_i,
  input  wire logic                 wvalid_i,
  output logic                      wready_o,
  output logic [1:0]                bresp_o,
  output logic                      bvalid_o,
  input  wire logic                 bready_i,
  input  wire logic [AddrWidth-1:0] araddr_i,
  input  wire logic                 arvalid_i,
  output logic                      arready_o,
  output logic [DataWidth-1:0]      rdata_o,
  output logic [1:0]                rresp_o,
  output logic                      rvalid_o,
  input  wire logic                 rready_i,
  output logic [DataWidth-1:0]      boot_addr_o,
  output logic                      fetch_enable_o,
  output logic                      timer_irq_o
);

  // Port to register block wiring
  logic                   soc_we;
  logic                   timer_we;
  logic [OffsetWidth-1:0] wr_offset;
  logic [DataWidth-1:0]   wr_data;
  logic [StrbWidth-1:0]   wr_strb;
  logic [OffsetWidth-1:0] rd_offset;
  logic [DataWidth-1:0]   soc_rdata;
  logic [DataWidth-1:0]   timer_rdata;

  axil_periph_port i_port (
    .clk_i,
    .rst_ni,
    .awaddr_i,
    .awvalid_i,
    .awready_o,
    .wdata_i,
    .wstrb_i,
    .wvalid_i,
    .wready_o,
    .bresp_o,
    .bvalid_o,
    .bready_i,
    .araddr_i,
    .arvalid_i,
    .arready_o,
    .rdata_o,
    .rresp_o,
    .rvalid_o,
    .rready_i,
    .soc_we_o      ( soc_we      ),
    .timer_we_o    ( timer_we    ),
    .wr_offset_o   ( wr_offset   ),
    .wr_data_o     ( wr_data     ),
    .wr_strb_o     ( wr_strb     ),
    .rd_offset_o   ( rd_offset   ),
    .soc_rdata_i   ( soc_rdata   ),
    .timer_rdata_i ( timer_rdata )
  );

  soc_ctrl_regs #(
    .BootAddrDefault ( BootAddrDefault )
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .we_i           ( soc_we    ),
    .wr_offset_i    ( wr_offset ),
    .wr_data_i      ( wr_data   ),
    .wr_strb_i      ( wr_strb   ),
    .rd_offset_i    ( rd_offset ),
    .rdata_o        ( soc_rdata ),
    .boot_addr_o,
    .fetch_enable_o
  );

  periph_timer i_timer (
    .clk_i,
    .rst_ni,
    .we_i        ( timer_we    ),
    .wr_offset_i ( wr_offset   ),
    .wr_data_i   ( wr_data     ),
    .wr_strb_i   ( wr_strb     ),
    .rd_offset_i ( rd_offset   ),
    .rdata_o     ( timer_rdata ),
    .irq_o       ( timer_irq_o )
  );

endmodule

`default_nettype wire

//--- hw/periph_timer.sv
// Free-running compare timer with a sticky interrupt.
// The counter runs while enabled, wraps to zero on a compare match and sets
// the pending bit; software clears pending by writing 1 to status bit 0.

`timescale 1ns/10ps
`default_nettype none

module periph_timer
  import periph_bus_pkg::*, periph_map_pkg::*;
(
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   we_i,
  input  wire logic [OffsetWidth-1:0] wr_offset_i,
  input  wire logic [DataWidth-1:0]   wr_data_i,
  input  wire logic [StrbWidth-1:0]   wr_strb_i,
  input  wire logic [OffsetWidth-1:0] rd_offset_i,
  output logic [DataWidth-1:0]        rdata_o,
  output logic                        irq_o
);

  logic                 enable_q;
  logic [DataWidth-1:0] count_q;
  logic [DataWidth-1:0] cmp_q;
  logic                 pending_q;
  logic                 match;
  logic                 ctrl_we;
  logic                 count_we;
  logic                 cmp_we;
  logic                 status_clr;

  assign ctrl_we    = we_i && (wr_offset_i == OffsetWidth'(TimerCtrlOffset)) && wr_strb_i[0];
  assign count_we   = we_i && (wr_offset_i == OffsetWidth'(TimerCountOffset));
  assign cmp_we     = we_i && (wr_offset_i == OffsetWidth'(TimerCmpOffset));
  assign status_clr = we_i && (wr_offset_i == OffsetWidth'(TimerStatusOffset))
                      && wr_strb_i[0] && wr_data_i[0];

  // Match only counts while the timer runs
  assign match = enable_q && (count_q == cmp_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q  <= 1'b0;
      count_q   <= '0;
      cmp_q     <= '0;
      pending_q <= 1'b0;
    end else begin
      if (ctrl_we) begin
        enable_q <= wr_data_i[0];
      end
      // Software write beats wrap and increment
      if (count_we) begin
        count_q <= apply_strb(count_q, wr_data_i, wr_strb_i);
      end else if (match) begin
        count_q <= '0;
      end else if (enable_q) begin
        count_q <= count_q + 1'b1;
      end
      if (cmp_we) begin
        cmp_q <= apply_strb(cmp_q, wr_data_i, wr_strb_i);
      end
      // Set wins over clear
      if (match) begin
        pending_q <= 1'b1;
      end else if (status_clr) begin
        pending_q <= 1'b0;
      end
    end
  end

  assign irq_o = pending_q;

  always_comb begin
    rdata_o = '0;
    case (rd_offset_i)
      OffsetWidth'(TimerCtrlOffset):   rdata_o[0] = enable_q;
      OffsetWidth'(TimerCountOffset):  rdata_o    = count_q;
      OffsetWidth'(TimerCmpOffset):    rdata_o    = cmp_q;
      OffsetWidth'(TimerStatusOffset): rdata_o[0] = pending_q;
      default:                         rdata_o    = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/soc_ctrl_regs.sv
// SoC control registers: boot address and fetch enable.
// Written by the bus port one word at a time under byte strobes; both values
// are also driven out as static control outputs.

`timescale 1ns/10ps
`default_nettype none

module soc_ctrl_regs
  import periph_bus_pkg::*, periph_map_pkg::*;
#(
  parameter logic [DataWidth-1:0] BootAddrDefault = 32'h0000_0080
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   we_i,
  input  wire logic [OffsetWidth-1:0] wr_offset_i,
  input  wire logic [DataWidth-1:0]   wr_data_i,
  input  wire logic [StrbWidth-1:0]   wr_strb_i,
  input  wire logic [OffsetWidth-1:0] rd_offset_i,
  output logic [DataWidth-1:0]        rdata_o,
  output logic [DataWidth-1:0]        boot_addr_o,
  output logic                        fetch_enable_o
);

  logic boot_addr_we;
  logic fetch_en_we;

  assign boot_addr_we = we_i && (wr_offset_i == OffsetWidth'(SocBootAddrOffset));
  // Fetch enable lives in byte 0 only
  assign fetch_en_we  = we_i && (wr_offset_i == OffsetWidth'(SocFetchEnOffset)) && wr_strb_i[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_o    <= BootAddrDefault;
      fetch_enable_o <= 1'b0;
    end else begin
      if (boot_addr_we) begin
        boot_addr_o <= apply_strb(boot_addr_o, wr_data_i, wr_strb_i);
      end
      if (fetch_en_we) begin
        fetch_enable_o <= wr_data_i[0];
      end
    end
  end

  // Read mux with unknown offsets reading as zero
  always_comb begin
    rdata_o = '0;
    if (rd_offset_i == OffsetWidth'(SocBootAddrOffset)) begin
      rdata_o = boot_addr_o;
    end else if (rd_offset_i == OffsetWidth'(SocFetchEnOffset)) begin
      rdata_o[0] = fetch_enable_o;
    end
  end

endmodule

`default_nettype wire
